// ==== verilog.f ====
hw/clb_pkg.sv
hw/smp_if.sv
hw/sys_bus_if.sv
hw/cal_chain.sv
hw/clb_regs.sv
hw/clb_top.sv
tb/clb_clk_gen.sv
tb/clb_tb.sv

// ==== Makefile ====
# verilator simulation of the calibration block

SIM   = verilator
FLAGS = --binary --timing --assert
TOP   = clb_tb
FLIST = verilog.f

.PHONY: sim clean

# pass only if the run prints the pass line
sim:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FLIST)
	@out="$$(./obj_dir/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "NO ERRORS"

clean:
	rm -rf obj_dir

// ==== tb/clb_tb.sv ====
/*
 * testbench for the calibration block
 * bus and stream tasks, reference model of both paths
 * directed tests and summary
 */
`timescale 1ns/10ps

module clb_tb;

  import clb_pkg::*;

  localparam int DAC_W = DAC_W_DEF;
  localparam int ADC_W = ADC_W_DEF;
  // cycles before any wait gives up
  localparam int TMO = 2000;
  // unity gain words
  localparam logic [31:0] DAC_ONE = 32'd1 << (DAC_W-2);
  localparam logic [31:0] ADC_ONE = 32'd1 << (ADC_W-2);

  logic                    clk;
  logic                    rst;
  logic [BUS_AW-1:0]       addr;
  logic [BUS_DW-1:0]       wdata;
  logic                    wen;
  logic                    ren;
  logic [BUS_DW-1:0]       rdata;
  logic                    ack;
  logic                    err;
  logic signed [DAC_W-1:0] gen_dat;
  logic                    gen_vld;
  logic                    gen_lst;
  logic                    gen_rdy;
  logic signed [DAC_W-1:0] dac_dat;
  logic                    dac_vld;
  logic                    dac_lst;
  logic                    dac_rdy;
  logic signed [ADC_W-1:0] adc_dat;
  logic                    adc_vld;
  logic                    adc_lst;
  logic                    adc_rdy;
  logic signed [ADC_W-1:0] osc_dat;
  logic                    osc_vld;
  logic                    osc_lst;
  logic                    osc_rdy;

  // collected output beats
  longint dac_q[$];
  logic   dac_lq[$];
  longint osc_q[$];
  logic   osc_lq[$];

  // model coefficients and expected sticky flags
  longint m_dg;
  longint m_do;
  longint m_ag;
  longint m_ao;
  bit     exp_dac_sat;
  bit     exp_adc_sat;

  // random output stalls while set
  bit bp_on;
  int errs;
  int errs_at;
  int nchk;
  int ntest;

  clb_clk_gen clk_gen_i (
    .clk (clk),
    .rst (rst)
  );

  clb_top #(
    .DAC_W (DAC_W),
    .ADC_W (ADC_W)
  ) clb_top_i (
    .clk     (clk),
    .rst     (rst),
    .addr    (addr),
    .wdata   (wdata),
    .wen     (wen),
    .ren     (ren),
    .rdata   (rdata),
    .ack     (ack),
    .err     (err),
    .gen_dat (gen_dat),
    .gen_vld (gen_vld),
    .gen_lst (gen_lst),
    .gen_rdy (gen_rdy),
    .dac_dat (dac_dat),
    .dac_vld (dac_vld),
    .dac_lst (dac_lst),
    .dac_rdy (dac_rdy),
    .adc_dat (adc_dat),
    .adc_vld (adc_vld),
    .adc_lst (adc_lst),
    .adc_rdy (adc_rdy),
    .osc_dat (osc_dat),
    .osc_vld (osc_vld),
    .osc_lst (osc_lst),
    .osc_rdy (osc_rdy)
  );

  // sink side, outputs are settled at the falling edge
  always @(negedge clk) begin
    if (!rst && dac_vld && dac_rdy) begin
      dac_q.push_back(longint'(dac_dat));
      dac_lq.push_back(dac_lst);
    end
    if (!rst && osc_vld && osc_rdy) begin
      osc_q.push_back(longint'(osc_dat));
      osc_lq.push_back(osc_lst);
    end
  end

  // output ready, random only under back-pressure
  initial begin
    dac_rdy = 1'b1;
    osc_rdy = 1'b1;
    forever begin
      @(posedge clk);
      #1;
      dac_rdy = bp_on ? (($urandom % 3) != 0) : 1'b1;
      osc_rdy = bp_on ? (($urandom % 3) != 0) : 1'b1;
    end
  end

  ////////////////////
  // reference model
  ////////////////////

  function automatic longint clip(input longint v, input int w);
    longint hi;
    longint lo;
    hi = (longint'(1) <<< (w-1)) - 1;
    lo = -(longint'(1) <<< (w-1));
    if (v > hi) return hi;
    if (v < lo) return lo;
    return v;
  endfunction

  // gain then offset, c set when a step clipped
  function automatic longint gen_model(input longint x, output bit c);
    longint p;
    longint a;
    longint r;
    p = (x * m_dg) >>> (DAC_W-2);
    a = clip(p, DAC_W);
    r = clip(a + m_do, DAC_W);
    c = (a != p) || (r != a + m_do);
    return r;
  endfunction

  // offset then gain
  function automatic longint osc_model(input longint x, output bit c);
    longint s;
    longint a;
    longint p;
    longint r;
    s = x + m_ao;
    a = clip(s, ADC_W);
    p = (a * m_ag) >>> (ADC_W-2);
    r = clip(p, ADC_W);
    c = (a != s) || (r != p);
    return r;
  endfunction

  // low w bits widened by their sign
  function automatic logic [31:0] sext(input logic [31:0] v, input int w);
    logic [31:0] m;
    m = 32'hffffffff << w;
    return v[w-1] ? (v | m) : (v & ~m);
  endfunction

  ////////////////////
  // reporting
  ////////////////////

  task automatic check_val(input string name, input longint got, input longint exp);
    nchk++;
    assert (got == exp) else begin
      $display("error at %0t ns: %s is %0d, expected %0d", $time, name, got, exp);
      errs++;
    end
  endtask

  task automatic finish_test(input string name);
    ntest++;
    $display("%s: %0d errors", name, errs - errs_at);
    errs_at = errs;
  endtask

  task automatic stop_on_timeout(input string what);
    $display("timeout at %0t ns waiting for %s", $time, what);
    $display("%0d tests, %0d checks, %0d errors", ntest, nchk, errs + 1);
    $display("ERRORS FOUND");
    $finish;
  endtask

  ////////////////////
  // bus access
  ////////////////////

  // cycles from strobe edge to ack seen
  task automatic wait_ack(output int lat);
    lat = 1;
    @(negedge clk);
    while (!ack && lat < TMO) begin
      lat++;
      @(negedge clk);
    end
    if (!ack) stop_on_timeout("bus ack");
    check_val("err", longint'(err), longint'(0));
  endtask

  task automatic bus_write(input logic [BUS_AW-1:0] a, input logic [31:0] d);
    int lat;
    addr  = a;
    wdata = d;
    wen   = 1'b1;
    @(posedge clk);
    #1;
    wen = 1'b0;
    wait_ack(lat);
    check_val("ack latency", longint'(lat), longint'(1));
    @(posedge clk);
    #1;
  endtask

  // read, compare data and ack latency
  task automatic read_check(input logic [BUS_AW-1:0] a, input logic [31:0] exp,
                            input string name);
    int lat;
    addr = a;
    ren  = 1'b1;
    @(posedge clk);
    #1;
    ren = 1'b0;
    wait_ack(lat);
    check_val(name, longint'(rdata), longint'(exp));
    check_val("ack latency", longint'(lat), longint'(1));
    @(posedge clk);
    #1;
  endtask

  task automatic set_coefs(input logic [31:0] dg, input logic [31:0] dof,
                           input logic [31:0] ag, input logic [31:0] aof);
    bus_write(REG_DAC_GAIN, dg);
    bus_write(REG_DAC_OFFS, dof);
    bus_write(REG_ADC_GAIN, ag);
    bus_write(REG_ADC_OFFS, aof);
    // bank keeps only the low sample width bits
    m_dg = longint'($signed(dg[DAC_W-1:0]));
    m_do = longint'($signed(dof[DAC_W-1:0]));
    m_ag = longint'($signed(ag[ADC_W-1:0]));
    m_ao = longint'($signed(aof[ADC_W-1:0]));
  endtask

  function automatic logic [31:0] sts_model();
    return (32'(exp_dac_sat) << STS_DAC_SAT) | (32'(exp_adc_sat) << STS_ADC_SAT);
  endfunction

  ////////////////////
  // streams
  ////////////////////

  // one beat, held until the handshake completes
  task automatic send_gen(input logic signed [DAC_W-1:0] d, input logic l);
    int k;
    gen_dat = d;
    gen_lst = l;
    gen_vld = 1'b1;
    k = 0;
    @(negedge clk);
    while (!gen_rdy && k < TMO) begin
      k++;
      @(negedge clk);
    end
    if (!gen_rdy) stop_on_timeout("gen_rdy");
    @(posedge clk);
    #1;
    gen_vld = 1'b0;
  endtask

  task automatic send_adc(input logic signed [ADC_W-1:0] d, input logic l);
    int k;
    adc_dat = d;
    adc_lst = l;
    adc_vld = 1'b1;
    k = 0;
    @(negedge clk);
    while (!adc_rdy && k < TMO) begin
      k++;
      @(negedge clk);
    end
    if (!adc_rdy) stop_on_timeout("adc_rdy");
    @(posedge clk);
    #1;
    adc_vld = 1'b0;
  endtask

  // n random beats per path, last one marked, checked in order
  task automatic run_stream(input int n, input bit bp);
    logic signed [DAC_W-1:0] gd[$];
    logic signed [ADC_W-1:0] ad[$];
    logic                    gl[$];
    logic                    al[$];
    longint                  dexp[$];
    longint                  aexp[$];
    bit                      c;
    int                      i;
    int                      j;
    int                      k;
    for (i = 0; i < n; i++) begin
      gd.push_back(DAC_W'($urandom));
      ad.push_back(ADC_W'($urandom));
      gl.push_back((i == n-1) || ($urandom % 5 == 0));
      al.push_back((i == n-1) || ($urandom % 5 == 0));
      dexp.push_back(gen_model(longint'(gd[i]), c));
      exp_dac_sat |= c;
      aexp.push_back(osc_model(longint'(ad[i]), c));
      exp_adc_sat |= c;
    end
    dac_q.delete();
    dac_lq.delete();
    osc_q.delete();
    osc_lq.delete();
    bp_on = bp;
    // both paths fed side by side
    fork
      begin
        for (i = 0; i < n; i++) send_gen(gd[i], gl[i]);
      end
      begin
        for (j = 0; j < n; j++) send_adc(ad[j], al[j]);
      end
    join
    k = 0;
    while ((dac_q.size() < n || osc_q.size() < n) && k < TMO) begin
      k++;
      @(negedge clk);
    end
    if (dac_q.size() < n || osc_q.size() < n) stop_on_timeout("stream outputs");
    bp_on = 1'b0;
    // last beats leave on the next edge, then nothing more
    @(negedge clk);
    nchk++;
    assert (!dac_vld && !osc_vld) else begin
      $display("error at %0t ns: output still valid after the last beat", $time);
      errs++;
    end
    check_val("dac beat count", longint'(dac_q.size()), longint'(n));
    check_val("osc beat count", longint'(osc_q.size()), longint'(n));
    for (i = 0; i < n; i++) begin
      check_val("dac_dat", dac_q[i], dexp[i]);
      check_val("dac_lst", longint'(dac_lq[i]), longint'(gl[i]));
      check_val("osc_dat", osc_q[i], aexp[i]);
      check_val("osc_lst", longint'(osc_lq[i]), longint'(al[i]));
    end
    @(posedge clk);
    #1;
  endtask

  ////////////////////
  // tests
  ////////////////////

  task automatic test_reset();
    read_check(REG_DAC_GAIN, DAC_ONE, "dac_gain");
    read_check(REG_DAC_OFFS, 32'd0, "dac_offs");
    read_check(REG_ADC_GAIN, ADC_ONE, "adc_gain");
    read_check(REG_ADC_OFFS, 32'd0, "adc_offs");
    read_check(REG_STATUS, 32'd0, "status");
    finish_test("reset defaults");
  endtask

  task automatic test_regs();
    logic [31:0] r0;
    logic [31:0] r1;
    logic [31:0] r2;
    logic [31:0] r3;
    int          k;
    for (k = 0; k < 4; k++) begin
      r0 = $urandom;
      r1 = $urandom;
      r2 = $urandom;
      r3 = $urandom;
      set_coefs(r0, r1, r2, r3);
      read_check(REG_DAC_GAIN, sext(r0, DAC_W), "dac_gain");
      read_check(REG_DAC_OFFS, sext(r1, DAC_W), "dac_offs");
      read_check(REG_ADC_GAIN, sext(r2, ADC_W), "adc_gain");
      read_check(REG_ADC_OFFS, sext(r3, ADC_W), "adc_offs");
    end
    // hole in the map
    bus_write(8'h14, $urandom);
    read_check(8'h14, 32'd0, "unmapped");
    set_coefs(DAC_ONE, 32'd0, ADC_ONE, 32'd0);
    finish_test("register access");
  endtask

  task automatic test_gen();
    run_stream(16, 1'b0);
    set_coefs($urandom, $urandom, ADC_ONE, 32'd0);
    run_stream(32, 1'b0);
    finish_test("generator path");
  endtask

  task automatic test_osc();
    set_coefs(DAC_ONE, 32'd0, $urandom, $urandom);
    run_stream(32, 1'b0);
    finish_test("oscilloscope path");
  endtask

  task automatic test_sat();
    // clear flags left by earlier streams
    read_check(REG_STATUS, sts_model(), "status");
    // gain near 2.0 on the generator only
    set_coefs(32'h1fff, 32'd0, ADC_ONE, 32'd0);
    run_stream(16, 1'b0);
    read_check(REG_STATUS, 32'd1 << STS_DAC_SAT, "status");
    read_check(REG_STATUS, 32'd0, "status");
    set_coefs(32'h1fff, 32'd0, 32'h7fff, 32'd0);
    run_stream(16, 1'b0);
    read_check(REG_STATUS, (32'd1 << STS_DAC_SAT) | (32'd1 << STS_ADC_SAT), "status");
    exp_dac_sat = 1'b0;
    exp_adc_sat = 1'b0;
    finish_test("saturation status");
  endtask

  task automatic test_bp();
    set_coefs($urandom, $urandom, $urandom, $urandom);
    run_stream(48, 1'b1);
    finish_test("back-pressure");
  endtask

  initial begin
    int k;
    void'($urandom(32'hd13b));
    addr        = '0;
    wdata       = '0;
    wen         = 1'b0;
    ren         = 1'b0;
    gen_dat     = '0;
    gen_vld     = 1'b0;
    gen_lst     = 1'b0;
    adc_dat     = '0;
    adc_vld     = 1'b0;
    adc_lst     = 1'b0;
    bp_on       = 1'b0;
    errs        = 0;
    errs_at     = 0;
    nchk        = 0;
    ntest       = 0;
    exp_dac_sat = 1'b0;
    exp_adc_sat = 1'b0;
    m_dg        = longint'(DAC_ONE);
    m_do        = 0;
    m_ag        = longint'(ADC_ONE);
    m_ao        = 0;
    // out of reset, aligned just after an edge
    k = 0;
    @(negedge clk);
    while (rst && k < TMO) begin
      k++;
      @(negedge clk);
    end
    if (rst) stop_on_timeout("reset release");
    @(posedge clk);
    #1;
    test_reset();
    test_regs();
    test_gen();
    test_osc();
    test_sat();
    test_bp();
    $display("%0d tests, %0d checks, %0d errors", ntest, nchk, errs);
    if (errs == 0) begin
      $display("NO ERRORS");
    end else begin
      $display("ERRORS FOUND");
    end
    $finish;
  end

endmodule : clb_tb

// ==== tb/clb_clk_gen.sv ====
/*
 * testbench clock and reset
 * 10 ns clock, reset high for two cycles
 */
`timescale 1ns/10ps

module clb_clk_gen (
  output logic clk,
  output logic rst
);

  // free running clock
  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  // release just after the second edge
  initial begin
    rst = 1'b1;
    repeat (2) @(posedge clk);
    #1;
    rst = 1'b0;
  end

endmodule : clb_clk_gen

// ==== hw/clb_top.sv ====
/*
 * calibration block top level
 * register bank plus generator and oscilloscope paths
 */
`timescale 1ns/10ps

module clb_top #(
  parameter int unsigned DAC_W = clb_pkg::DAC_W_DEF,
  parameter int unsigned ADC_W = clb_pkg::ADC_W_DEF
)(
  input  logic                            clk,
  input  logic                            rst,
  // system bus
  input  logic [clb_pkg::BUS_AW-1:0]      addr,
  input  logic [clb_pkg::BUS_DW-1:0]      wdata,
  input  logic                            wen,
  input  logic                            ren,
  output logic [clb_pkg::BUS_DW-1:0]      rdata,
  output logic                            ack,
  output logic                            err,
  // generator stream in
  input  logic signed [DAC_W-1:0]         gen_dat,
  input  logic                            gen_vld,
  input  logic                            gen_lst,
  output logic                            gen_rdy,
  // DAC stream out
  output logic signed [DAC_W-1:0]         dac_dat,
  output logic                            dac_vld,
  output logic                            dac_lst,
  input  logic                            dac_rdy,
  // ADC stream in
  input  logic signed [ADC_W-1:0]         adc_dat,
  input  logic                            adc_vld,
  input  logic                            adc_lst,
  output logic                            adc_rdy,
  // oscilloscope stream out
  output logic signed [ADC_W-1:0]         osc_dat,
  output logic                            osc_vld,
  output logic                            osc_lst,
  input  logic                            osc_rdy
);

  // coefficients and saturation pulses
  logic signed [DAC_W-1:0] dac_gain;
  logic signed [DAC_W-1:0] dac_offs;
  logic signed [ADC_W-1:0] adc_gain;
  logic signed [ADC_W-1:0] adc_offs;
  logic                    dac_sat;
  logic                    adc_sat;

  ////////////////////
  // bus
  ////////////////////

  sys_bus_if bus_i ();

  assign bus_i.addr  = addr;
  assign bus_i.wdata = wdata;
  assign bus_i.wen   = wen;
  assign bus_i.ren   = ren;
  assign rdata       = bus_i.rdata;
  assign ack         = bus_i.ack;
  assign err         = bus_i.err;

  clb_regs #(
    .DAC_W (DAC_W),
    .ADC_W (ADC_W)
  ) clb_regs_i (
    .clk      (clk),
    .rst      (rst),
    .bus      (bus_i),
    .dac_gain (dac_gain),
    .dac_offs (dac_offs),
    .adc_gain (adc_gain),
    .adc_offs (adc_offs),
    .dac_sat  (dac_sat),
    .adc_sat  (adc_sat)
  );

  ////////////////////
  // generator path
  ////////////////////

  smp_if #(.W(DAC_W)) gen_i ();
  smp_if #(.W(DAC_W)) dac_i ();

  assign gen_i.dat = gen_dat;
  assign gen_i.vld = gen_vld;
  assign gen_i.lst = gen_lst;
  assign gen_rdy   = gen_i.rdy;
  assign dac_dat   = dac_i.dat;
  assign dac_vld   = dac_i.vld;
  assign dac_lst   = dac_i.lst;
  assign dac_i.rdy = dac_rdy;

  // gain then offset
  cal_chain #(.W(DAC_W), .OFFS_FIRST(1'b0)) gen_cal (
    .clk  (clk),
    .rst  (rst),
    .sin  (gen_i),
    .sout (dac_i),
    .gain (dac_gain),
    .offs (dac_offs),
    .sat  (dac_sat)
  );

  ////////////////////
  // oscilloscope path
  ////////////////////

  smp_if #(.W(ADC_W)) adc_i ();
  smp_if #(.W(ADC_W)) osc_i ();

  assign adc_i.dat = adc_dat;
  assign adc_i.vld = adc_vld;
  assign adc_i.lst = adc_lst;
  assign adc_rdy   = adc_i.rdy;
  assign osc_dat   = osc_i.dat;
  assign osc_vld   = osc_i.vld;
  assign osc_lst   = osc_i.lst;
  assign osc_i.rdy = osc_rdy;

  // offset then gain
  cal_chain #(.W(ADC_W), .OFFS_FIRST(1'b1)) osc_cal (
    .clk  (clk),
    .rst  (rst),
    .sin  (adc_i),
    .sout (osc_i),
    .gain (adc_gain),
    .offs (adc_offs),
    .sat  (adc_sat)
  );

endmodule : clb_top

// ==== hw/clb_regs.sv ====
/*
 * bus register bank for the calibration block
 * gain and offset per path, sticky saturation status
 */
`timescale 1ns/10ps

module clb_regs #(
  parameter int unsigned DAC_W = clb_pkg::DAC_W_DEF,
  parameter int unsigned ADC_W = clb_pkg::ADC_W_DEF
)(
  input  logic                    clk,
  input  logic                    rst,
  sys_bus_if.slv                  bus,
  // coefficients toward the paths
  output logic signed [DAC_W-1:0] dac_gain,
  output logic signed [DAC_W-1:0] dac_offs,
  output logic signed [ADC_W-1:0] adc_gain,
  output logic signed [ADC_W-1:0] adc_offs,
  // saturation pulses from the paths
  input  logic                    dac_sat,
  input  logic                    adc_sat
);

  import clb_pkg::*;

  // unity gain per width
  localparam logic signed [DAC_W-1:0] DAC_ONE = DAC_W'(1) << (DAC_W-2);
  localparam logic signed [ADC_W-1:0] ADC_ONE = ADC_W'(1) << (ADC_W-2);

  logic [BUS_DW-1:0] sts;
  logic [BUS_DW-1:0] sts_set;
  logic              sts_rd;

  ////////////////////
  // coefficients
  ////////////////////

  // low sample width bits of wdata
  always_ff @(posedge clk) begin
    if (rst) begin
      dac_gain <= DAC_ONE;
      dac_offs <= '0;
      adc_gain <= ADC_ONE;
      adc_offs <= '0;
    end else if (bus.wen) begin
      case (bus.addr)
        REG_DAC_GAIN: dac_gain <= bus.wdata[DAC_W-1:0];
        REG_DAC_OFFS: dac_offs <= bus.wdata[DAC_W-1:0];
        REG_ADC_GAIN: adc_gain <= bus.wdata[ADC_W-1:0];
        REG_ADC_OFFS: adc_offs <= bus.wdata[ADC_W-1:0];
        // status read only, rest unmapped
        default: ;
      endcase
    end
  end

  ////////////////////
  // status
  ////////////////////

  // pulses placed at their bit positions
  always_comb begin
    sts_set              = '0;
    sts_set[STS_DAC_SAT] = dac_sat;
    sts_set[STS_ADC_SAT] = adc_sat;
  end

  assign sts_rd = bus.ren && (bus.addr == REG_STATUS);

  // clear on read, a pulse in that cycle survives
  always_ff @(posedge clk) begin
    if (rst) begin
      sts <= '0;
    end else begin
      sts <= (sts_rd ? '0 : sts) | sts_set;
    end
  end

  ////////////////////
  // bus response
  ////////////////////

  always_ff @(posedge clk) begin
    if (rst) begin
      bus.ack <= 1'b0;
    end else begin
      bus.ack <= bus.wen | bus.ren;
    end
  end

  // no error responses
  assign bus.err = 1'b0;

  // coefficients sign extended, unmapped reads zero
  always_ff @(posedge clk) begin
    if (bus.ren) begin
      case (bus.addr)
        REG_DAC_GAIN: bus.rdata <= {{(BUS_DW-DAC_W){dac_gain[DAC_W-1]}}, dac_gain};
        REG_DAC_OFFS: bus.rdata <= {{(BUS_DW-DAC_W){dac_offs[DAC_W-1]}}, dac_offs};
        REG_ADC_GAIN: bus.rdata <= {{(BUS_DW-ADC_W){adc_gain[ADC_W-1]}}, adc_gain};
        REG_ADC_OFFS: bus.rdata <= {{(BUS_DW-ADC_W){adc_offs[ADC_W-1]}}, adc_offs};
        REG_STATUS:   bus.rdata <= sts;
        default:      bus.rdata <= '0;
      endcase
    end
  end

  ////////////////////
  // checks
  ////////////////////

  // strobes last a single cycle
  a_strobe_pulse: assert property (@(posedge clk) disable iff (rst)
    (bus.wen || bus.ren) |=> !(bus.wen || bus.ren));

  // one access at a time
  a_one_strobe: assert property (@(posedge clk) disable iff (rst)
    !(bus.wen && bus.ren));

endmodule : clb_regs

// ==== hw/cal_chain.sv ====
/*
 * two stage gain and offset pipeline
 * saturating arithmetic, stage order set by OFFS_FIRST
 * saturation pulse toward the register bank
 */
`timescale 1ns/10ps

module cal_chain #(
  parameter int unsigned W          = 14,
  parameter bit          OFFS_FIRST = 1'b0
)(
  input  logic                clk,
  input  logic                rst,
  smp_if.snk                  sin,
  smp_if.src                  sout,
  input  logic signed [W-1:0] gain,
  input  logic signed [W-1:0] offs,
  output logic                sat
);

  // saturation limits
  localparam logic signed [W-1:0] SMAX = {1'b0, {(W-1){1'b1}}};
  localparam logic signed [W-1:0] SMIN = {1'b1, {(W-1){1'b0}}};

  ////////////////////
  // arithmetic
  ////////////////////

  // offset step, result is {clip, value}
  function automatic logic [W:0] add_sat(
    input logic signed [W-1:0] a,
    input logic signed [W-1:0] b
  );
    logic signed [W:0] sum;
    sum = a + b;
    // overflow when the two top bits differ
    if (sum[W] != sum[W-1]) begin
      return {1'b1, (sum[W] ? SMIN : SMAX)};
    end
    return {1'b0, sum[W-1:0]};
  endfunction

  // gain step, 1.0 is 1 << (W-2)
  function automatic logic [W:0] mul_sat(
    input logic signed [W-1:0] a,
    input logic signed [W-1:0] g
  );
    logic signed [2*W-1:0] prod;
    logic signed [2*W-1:0] shf;
    prod = a * g;
    // arithmetic shift truncates toward minus infinity
    shf = prod >>> (W-2);
    // fits only if all bits above the sign match it
    if (!(&shf[2*W-1:W-1]) && (|shf[2*W-1:W-1])) begin
      return {1'b1, (shf[2*W-1] ? SMIN : SMAX)};
    end
    return {1'b0, shf[W-1:0]};
  endfunction

  ////////////////////
  // pipeline control
  ////////////////////

  logic                s1_vld;
  logic                s2_vld;
  logic                s1_adv;
  logic                s2_adv;

  // stage payload
  logic signed [W-1:0] s1_dat;
  logic signed [W-1:0] s1_coef;
  logic                s1_lst;
  logic                s1_clip;
  logic signed [W-1:0] s2_dat;
  logic                s2_lst;
  logic                s2_sat;

  // step results, {clip, value}
  logic [W:0]          s1_res;
  logic [W:0]          s2_res;

  // a stage moves when empty or when the next one moves
  assign s2_adv = !s2_vld || sout.rdy;
  assign s1_adv = !s1_vld || s2_adv;

  // input stalls only with both stages full
  assign sin.rdy = s1_adv;

  always_ff @(posedge clk) begin
    if (rst) begin
      s1_vld <= 1'b0;
      s2_vld <= 1'b0;
    end else begin
      if (s1_adv) s1_vld <= sin.vld;
      if (s2_adv) s2_vld <= s1_vld;
    end
  end

  ////////////////////
  // stage one
  ////////////////////

  assign s1_res = OFFS_FIRST ? add_sat(sin.dat, offs) : mul_sat(sin.dat, gain);

  // second coefficient sampled with the beat
  always_ff @(posedge clk) begin
    if (s1_adv && sin.vld) begin
      s1_dat  <= s1_res[W-1:0];
      s1_clip <= s1_res[W];
      s1_lst  <= sin.lst;
      s1_coef <= OFFS_FIRST ? gain : offs;
    end
  end

  ////////////////////
  // stage two
  ////////////////////

  assign s2_res = OFFS_FIRST ? mul_sat(s1_dat, s1_coef) : add_sat(s1_dat, s1_coef);

  always_ff @(posedge clk) begin
    if (s2_adv && s1_vld) begin
      s2_dat <= s2_res[W-1:0];
      s2_lst <= s1_lst;
      // clipped in either stage
      s2_sat <= s1_clip | s2_res[W];
    end
  end

  assign sout.dat = s2_dat;
  assign sout.lst = s2_lst;
  assign sout.vld = s2_vld;

  // pulse as the clipped beat leaves
  assign sat = s2_vld && sout.rdy && s2_sat;

  ////////////////////
  // checks
  ////////////////////

  // stalled beat held until taken
  a_stall_hold: assert property (@(posedge clk) disable iff (rst)
    sout.vld && !sout.rdy |=> sout.vld && $stable(sout.dat) && $stable(sout.lst));

endmodule : cal_chain

// ==== hw/sys_bus_if.sv ====
/*
 * simple system bus interface
 * single cycle strobes, ack one cycle later
 */
`timescale 1ns/10ps

interface sys_bus_if;

  import clb_pkg::*;

  // request, from master
  logic [BUS_AW-1:0] addr;
  logic [BUS_DW-1:0] wdata;
  logic              wen;
  logic              ren;

  // response, from slave
  logic [BUS_DW-1:0] rdata;
  logic              ack;
  logic              err;

  // bus controller side
  modport mst (
    output addr,
    output wdata,
    output wen,
    output ren,
    input  rdata,
    input  ack,
    input  err
  );

  // register bank side
  modport slv (
    input  addr,
    input  wdata,
    input  wen,
    input  ren,
    output rdata,
    output ack,
    output err
  );

endinterface : sys_bus_if

// ==== hw/smp_if.sv ====
/*
 * sample stream interface
 * signed data, valid/ready handshake, block end marker
 */
`timescale 1ns/10ps

interface smp_if #(
  parameter int unsigned W = 16
);

  // sample payload
  logic signed [W-1:0] dat;
  // end of block, travels with dat
  logic                lst;
  // handshake, beat moves when both high
  logic                vld;
  logic                rdy;

  // producer side
  modport src (
    output dat,
    output lst,
    output vld,
    input  rdy
  );

  // consumer side
  modport snk (
    input  dat,
    input  lst,
    input  vld,
    output rdy
  );

endinterface : smp_if

// ==== hw/clb_pkg.sv ====
/*
 * shared definitions for the calibration block
 * bus widths, default sample widths
 * register map and status bit positions
 */

package clb_pkg;

  ////////////////////
  // system bus
  ////////////////////

  // byte address width
  localparam int unsigned BUS_AW = 8;
  // data width
  localparam int unsigned BUS_DW = 32;

  ////////////////////
  // sample widths
  ////////////////////

  // generator toward DAC
  localparam int unsigned DAC_W_DEF = 14;
  // oscilloscope from ADC
  localparam int unsigned ADC_W_DEF = 16;

  ////////////////////
  // register map
  ////////////////////

  // byte addresses, one 32 bit word each
  typedef enum logic [BUS_AW-1:0] {
    REG_DAC_GAIN = BUS_AW'('h00),
    REG_DAC_OFFS = BUS_AW'('h04),
    REG_ADC_GAIN = BUS_AW'('h08),
    REG_ADC_OFFS = BUS_AW'('h0C),
    REG_STATUS   = BUS_AW'('h10)
  } reg_addr_t;

  // sticky saturation flags in REG_STATUS
  localparam int unsigned STS_DAC_SAT = 0;
  localparam int unsigned STS_ADC_SAT = 1;

endpackage : clb_pkg
